/* design/daq_pkg.sv */
package daq_pkg;

	typedef logic [15:0] word_t;     // Low byte goes out first
	typedef logic [1:0]  charisk_t;  // One K flag per byte
	typedef logic [15:0] crc_t;
	typedef logic [9:0]  pkt_len_t;
	typedef logic [2:0]  rom_addr_t;

	typedef enum logic [3:0] {
		ST_IDLE, ST_SOP, ST_PREAMBLE, ST_SOF, ST_DATA, ST_TAIL, ST_EOP, ST_EXTEND, ST_GAP
	} frame_state_t;

	//////////////////////
	// 8b/10b octets
	//////////////////////
	localparam logic [7:0] K28_5    = 8'hBC;
	localparam logic [7:0] D16_2    = 8'h50;
	localparam logic [7:0] K27_7    = 8'hFB;  // /S/ start of packet
	localparam logic [7:0] K23_7    = 8'hF7;  // /R/ carrier extend
	localparam logic [7:0] K29_7    = 8'hFD;  // /T/ end of packet
	localparam logic [7:0] PRMBL    = 8'h55;
	localparam logic [7:0] SOF_BYTE = 8'hD5;

	//////////////////////
	// Frame words and K flags
	//////////////////////
	localparam word_t IDLE2          = {D16_2, K28_5};
	localparam word_t SOP_PRE        = {PRMBL, K27_7};
	localparam word_t PREAMBLE       = {PRMBL, PRMBL};
	localparam word_t SOF_PRE        = {SOF_BYTE, PRMBL};
	localparam word_t DATA_FILL      = 16'h0000;
	localparam word_t END_OF_PACKET  = {K23_7, K29_7};
	localparam word_t CARRIER_EXTEND = {K23_7, K23_7};

	localparam charisk_t IDLE2_K          = 2'b01;
	localparam charisk_t SOP_PRE_K        = 2'b01;
	localparam charisk_t PREAMBLE_K       = 2'b00;
	localparam charisk_t SOF_PRE_K        = 2'b00;
	localparam charisk_t DATA_FILL_K      = 2'b00;
	localparam charisk_t END_OF_PACKET_K  = 2'b11;
	localparam charisk_t CARRIER_EXTEND_K = 2'b11;

	// Frame word table addresses
	localparam rom_addr_t ROM_IDLE = 3'd0;
	localparam rom_addr_t ROM_SOP  = 3'd1;
	localparam rom_addr_t ROM_PRE  = 3'd2;
	localparam rom_addr_t ROM_SOF  = 3'd3;
	localparam rom_addr_t ROM_FILL = 3'd4;
	localparam rom_addr_t ROM_EOP  = 3'd5;
	localparam rom_addr_t ROM_EXT  = 3'd6;

	localparam crc_t CRC_POLY = 16'h1021;  // CRC-16-CCITT
	localparam crc_t CRC_INIT = 16'hFFFF;

	localparam pkt_len_t PKT_LEN_RST = 10'd800;  // Reported before the first frame

endpackage

/* design/frame_fsm.sv */
`timescale 1ns/100ps

module frame_fsm
	import daq_pkg::*;
#(
	parameter int PREAMBLE_WORDS = 2,
	parameter int GAP_WORDS      = 6
)
(
	input  logic      usr_clk_wordwise,
	input  logic      arst,
	input  logic      txd_vld_i,
	input  logic      timer_done_i,
	output rom_addr_t rom_addr_o,
	output logic      crc_calc_o,
	output logic      clr_crc_o,
	output logic      tx_ack_o,
	output logic      timer_load_o,
	output pkt_len_t  timer_count_o
);

	// DATA runs one cycle past the last word and that cycle fills the first CRC slot,
	// so TAIL itself only covers the second one
	localparam int TAIL_WORDS = 1;

	frame_state_t state;
	frame_state_t state_nxt;

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:     if (txd_vld_i) state_nxt = ST_SOP;
			ST_SOP:      state_nxt = ST_PREAMBLE;
			ST_PREAMBLE: if (timer_done_i) state_nxt = ST_SOF;
			ST_SOF:      state_nxt = ST_DATA;
			ST_DATA:     if (!txd_vld_i) state_nxt = ST_TAIL;  // Request dropped
			ST_TAIL:     if (timer_done_i) state_nxt = ST_EOP;
			ST_EOP:      state_nxt = ST_EXTEND;
			ST_EXTEND:   state_nxt = ST_GAP;
			ST_GAP:      if (timer_done_i) state_nxt = ST_IDLE;
			default:     state_nxt = ST_IDLE;
		endcase
	end

	//////////////////////
	// Section timer control
	//////////////////////
	assign timer_load_o = (state_nxt != state) &&
		(state_nxt inside {ST_PREAMBLE, ST_TAIL, ST_GAP});

	always_comb
	begin
		case (state_nxt)
			ST_PREAMBLE: timer_count_o = pkt_len_t'(PREAMBLE_WORDS);
			ST_TAIL:     timer_count_o = pkt_len_t'(TAIL_WORDS);
			default:     timer_count_o = pkt_len_t'(GAP_WORDS);
		endcase
	end

	// Fill keeps K flags at 00 under payload and CRC
	always_comb
	begin
		case (state)
			ST_SOP:           rom_addr_o = ROM_SOP;
			ST_PREAMBLE:      rom_addr_o = ROM_PRE;
			ST_SOF:           rom_addr_o = ROM_SOF;
			ST_DATA, ST_TAIL: rom_addr_o = ROM_FILL;
			ST_EOP:           rom_addr_o = ROM_EOP;
			ST_EXTEND:        rom_addr_o = ROM_EXT;
			default:          rom_addr_o = ROM_IDLE;
		endcase
	end

	assign tx_ack_o   = (state == ST_DATA);
	assign crc_calc_o = tx_ack_o & txd_vld_i;  // Word taken on this edge
	assign clr_crc_o  = (state == ST_SOF);

endmodule

/* design/word_timer.sv */
`timescale 1ns/100ps

module word_timer
	import daq_pkg::*;
(
	input  logic     usr_clk_wordwise,
	input  logic     arst,
	input  logic     load_i,
	input  pkt_len_t count_i,
	output logic     done_o
);

	pkt_len_t cnt;

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			cnt <= '0;
		else if (load_i)
			cnt <= count_i;
		else if (cnt != '0)
			cnt <= cnt - 1'b1;  // Stops at zero
	end

	// Last cycle of a loaded section of N words
	assign done_o = (cnt == pkt_len_t'(1)) || ((cnt == '0) && !load_i);

endmodule

/* design/crc16_gen.sv */
`timescale 1ns/100ps

module crc16_gen
	import daq_pkg::*;
(
	input  logic  usr_clk_wordwise,
	input  logic  arst,
	input  word_t data_i,
	input  logic  calc_i,
	input  logic  init_i,
	output crc_t  crc_o
);

	// Bit serial fold of one word from the MSB down
	function automatic crc_t crc_next(input crc_t crc_in, input word_t data);
		crc_t c;
		logic fb;
		c = crc_in;
		for (int i = $bits(word_t) - 1; i >= 0; i--)
		begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_o <= CRC_INIT;
		else if (init_i)
			crc_o <= CRC_INIT;  // New frame
		else if (calc_i)
			crc_o <= crc_next(crc_o, data_i);
	end

endmodule

/* design/tx_word_pipe.sv */
`timescale 1ns/100ps

module tx_word_pipe
	import daq_pkg::*;
(
	input  logic      usr_clk_wordwise,
	input  logic      arst,
	input  rom_addr_t rom_addr_i,
	input  word_t     txd_i,
	input  logic      crc_calc_i,
	input  crc_t      crc_i,
	output word_t     tx_data_o,
	output charisk_t  tx_charisk_o,
	output logic      frame_end_o
);

	word_t    rom_word;
	charisk_t rom_k;
	word_t    data_d;
	logic     calc_d;
	logic     calc_fall;
	logic     crc_sel1;
	logic     crc_sel2;

	//////////////////////
	// Frame word ROM
	//////////////////////
	always_ff @(posedge usr_clk_wordwise)
	begin
		case (rom_addr_i)
			ROM_IDLE: {rom_k, rom_word} <= {IDLE2_K, IDLE2};
			ROM_SOP:  {rom_k, rom_word} <= {SOP_PRE_K, SOP_PRE};
			ROM_PRE:  {rom_k, rom_word} <= {PREAMBLE_K, PREAMBLE};
			ROM_SOF:  {rom_k, rom_word} <= {SOF_PRE_K, SOF_PRE};
			ROM_FILL: {rom_k, rom_word} <= {DATA_FILL_K, DATA_FILL};
			ROM_EOP:  {rom_k, rom_word} <= {END_OF_PACKET_K, END_OF_PACKET};
			ROM_EXT:  {rom_k, rom_word} <= {CARRIER_EXTEND_K, CARRIER_EXTEND};
			default:  {rom_k, rom_word} <= {IDLE2_K, IDLE2};
		endcase
	end

	// Payload stage lines up with the ROM output
	always_ff @(posedge usr_clk_wordwise)
	begin
		data_d <= txd_i;
	end

	assign calc_fall = calc_d & ~crc_calc_i;  // Last payload word just taken

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			calc_d   <= 1'b0;
			crc_sel1 <= 1'b0;
			crc_sel2 <= 1'b0;
		end
		else
		begin
			calc_d   <= crc_calc_i;
			crc_sel1 <= calc_fall;
			crc_sel2 <= crc_sel1;
		end
	end

	//////////////////////
	// Output register
	//////////////////////
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			tx_data_o    <= IDLE2;
			tx_charisk_o <= IDLE2_K;
		end
		else
		begin
			tx_data_o    <= (crc_sel1 || crc_sel2) ? crc_i : (calc_d ? data_d : rom_word);
			tx_charisk_o <= rom_k;
		end
	end

	assign frame_end_o = crc_sel1;

endmodule

/* design/pkt_len_counter.sv */
`timescale 1ns/100ps

module pkt_len_counter
	import daq_pkg::*;
(
	input  logic     usr_clk_wordwise,
	input  logic     arst,
	input  logic     crc_calc_i,
	input  logic     clr_i,
	input  logic     frame_end_i,
	output pkt_len_t pkt_len_o
);

	pkt_len_t cnt;  // Words of the frame in flight

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			cnt <= '0;
		else if (clr_i)
			cnt <= '0;
		else if (crc_calc_i)
			cnt <= cnt + 1'b1;
	end

	// Hold the last complete frame
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			pkt_len_o <= PKT_LEN_RST;
		else if (frame_end_i)
			pkt_len_o <= cnt;
	end

endmodule

/* design/daq_frame_tx.sv */
`timescale 1ns/100ps

module daq_frame_tx
	import daq_pkg::*;
#(
	parameter int PREAMBLE_WORDS = 2,
	parameter int GAP_WORDS      = 6
)
(
	input  logic     usr_clk_wordwise,
	input  logic     arst,
	input  word_t    txd_i,
	input  logic     txd_vld_i,
	output word_t    tx_data_o,
	output charisk_t tx_charisk_o,
	output logic     tx_ack_o,
	output pkt_len_t pkt_len_o
);

	rom_addr_t rom_addr;
	logic      crc_calc;
	logic      clr_crc;
	logic      timer_load;
	pkt_len_t  timer_count;
	logic      timer_done;
	crc_t      crc;
	logic      frame_end;

	//////////////////////
	// Control
	//////////////////////
	frame_fsm #(
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.GAP_WORDS      (GAP_WORDS)
	) u_frame_fsm (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_vld_i        (txd_vld_i),
		.timer_done_i     (timer_done),
		.rom_addr_o       (rom_addr),
		.crc_calc_o       (crc_calc),
		.clr_crc_o        (clr_crc),
		.tx_ack_o         (tx_ack_o),
		.timer_load_o     (timer_load),
		.timer_count_o    (timer_count)
	);

	word_timer u_word_timer (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.load_i           (timer_load),
		.count_i          (timer_count),
		.done_o           (timer_done)
	);

	//////////////////////
	// Data path
	//////////////////////
	crc16_gen u_crc16_gen (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.data_i           (txd_i),
		.calc_i           (crc_calc),
		.init_i           (clr_crc),
		.crc_o            (crc)
	);

	tx_word_pipe u_tx_word_pipe (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.rom_addr_i       (rom_addr),
		.txd_i            (txd_i),
		.crc_calc_i       (crc_calc),
		.crc_i            (crc),
		.tx_data_o        (tx_data_o),
		.tx_charisk_o     (tx_charisk_o),
		.frame_end_o      (frame_end)
	);

	pkt_len_counter u_pkt_len_counter (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.crc_calc_i       (crc_calc),
		.clr_i            (clr_crc),
		.frame_end_i      (frame_end),
		.pkt_len_o        (pkt_len_o)
	);

endmodule

/* tests/daq_frame_asserts.sv */
`timescale 1ns/100ps

module daq_frame_asserts
	import daq_pkg::*;
(
	input logic     usr_clk_wordwise,
	input logic     arst,
	input logic     txd_vld_i,
	input logic     tx_ack_i,
	input charisk_t tx_charisk_i
);

	int fail_cnt = 0;  // Read back at the end of the run

	// High byte alone as K is no valid word
	charisk_legal: assert property (
		@(posedge usr_clk_wordwise) disable iff (arst) tx_charisk_i != 2'b10
	)
	else
	begin
		$error("K flags 10 on the output word");
		fail_cnt++;
	end

	ack_after_request: assert property (
		@(posedge usr_clk_wordwise) disable iff (arst) $rose(tx_ack_i) |-> $past(txd_vld_i)
	)
	else
	begin
		$error("tx_ack_o rose without a request");
		fail_cnt++;
	end

	ack_low_out_of_reset: assert property (
		@(posedge usr_clk_wordwise) $fell(arst) |-> !tx_ack_i
	)
	else
	begin
		$error("tx_ack_o high right after reset");
		fail_cnt++;
	end

endmodule

bind daq_frame_tx daq_frame_asserts u_daq_frame_asserts (
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst             (arst),
	.txd_vld_i        (txd_vld_i),
	.tx_ack_i         (tx_ack_o),
	.tx_charisk_i     (tx_charisk_o)
);

/* tests/daq_frame_checker.sv */
`timescale 1ns/100ps

module daq_frame_checker
	import daq_pkg::*;
#(
	parameter int PREAMBLE_WORDS = 2,
	parameter int GAP_WORDS      = 6
)
(
	input  logic     usr_clk_wordwise,
	input  logic     arst,
	input  word_t    tx_data_i,
	input  charisk_t tx_charisk_i,
	input  logic     tx_ack_i,
	input  pkt_len_t pkt_len_i,
	output int       err_cnt_o,
	output int       frames_done_o
);

	typedef enum logic [2:0] {
		C_IDLE, C_PRE, C_SOF, C_DATA, C_CRC1, C_CRC2, C_EOP, C_EXT
	} chk_state_t;

	word_t      exp_words[$];  // Payload of every queued frame
	int         exp_lens[$];
	word_t      cur_words[$];
	int         cur_len = 0;
	int         idx = 0;
	crc_t       exp_crc = CRC_INIT;
	pkt_len_t   exp_pkt_len = PKT_LEN_RST;
	chk_state_t cstate = C_IDLE;
	int         idle_run = 0;
	int         frame_err0 = 0;
	int         err_cnt = 0;
	int         frames_done = 0;
	logic       line_pending = 1'b0;  // Frame done but length not yet compared
	logic       reset_seen = 1'b0;

	assign err_cnt_o     = err_cnt;
	assign frames_done_o = frames_done;

	task automatic add_word(input word_t w);
		exp_words.push_back(w);
	endtask

	task automatic add_frame(input int len);
		exp_lens.push_back(len);
	endtask

	// CCITT polynomial with data MSB first
	function automatic crc_t crc_fold(input crc_t crc, input word_t w);
		crc_t  r;
		word_t d;
		logic  fb;
		r = crc;
		d = w;
		repeat (16)
		begin
			fb = r[15] ^ d[15];
			r  = r << 1;
			if (fb)
				r = r ^ CRC_POLY;
			d = d << 1;
		end
		return r;
	endfunction

	task automatic expect_word(input string what, input word_t exp_w, input charisk_t exp_k);
		if (tx_data_i !== exp_w || tx_charisk_i !== exp_k)
		begin
			$display("FAIL %0t: %s is %h/%b, expected %h/%b",
				$time, what, tx_data_i, tx_charisk_i, exp_w, exp_k);
			err_cnt++;
		end
	endtask

	task automatic finish_frame();
		if (pkt_len_i !== pkt_len_t'(cur_len))
		begin
			$display("FAIL %0t: packet length %0d, expected %0d", $time, pkt_len_i, cur_len);
			err_cnt++;
		end
		exp_pkt_len = pkt_len_t'(cur_len);
		frames_done++;
		if (err_cnt == frame_err0)
			$display("Frame %0d, %0d words: passed", frames_done, cur_len);
		else
			$display("Frame %0d, %0d words: %0d errors", frames_done, cur_len,
				err_cnt - frame_err0);
		line_pending = 1'b0;
	endtask

	task automatic start_frame();
		if (line_pending)
		begin
			$display("No idle word after frame %0d at %0t", frames_done + 1, $time);
			err_cnt++;
			finish_frame();
		end
		frame_err0 = err_cnt;
		if (frames_done > 0 && idle_run < GAP_WORDS)
		begin
			$display("FAIL %0t: gap of %0d idle words, minimum %0d", $time, idle_run, GAP_WORDS);
			err_cnt++;
		end
		cur_words.delete();
		exp_crc = CRC_INIT;
		if (exp_lens.size() == 0)
		begin
			$display("Start of packet at %0t with no frame queued", $time);
			err_cnt++;
			cur_len = 0;
		end
		else
		begin
			cur_len = exp_lens.pop_front();
			for (int i = 0; i < cur_len; i++)
			begin
				cur_words.push_back(exp_words.pop_front());
				exp_crc = crc_fold(exp_crc, cur_words[i]);
			end
		end
	endtask

	//////////////////////
	// Output stream parser
	//////////////////////
	always @(negedge usr_clk_wordwise)
	begin
		if (!arst)
		begin
			if (!reset_seen)
				frame_err0 = err_cnt;
			case (cstate)
				C_IDLE:
				begin
					if (tx_data_i === SOP_PRE)
					begin
						start_frame();
						expect_word("start of packet", SOP_PRE, SOP_PRE_K);
						idx    = 0;
						cstate = C_PRE;
					end
					else
					begin
						expect_word("idle word", IDLE2, IDLE2_K);
						if (tx_ack_i !== 1'b0)
						begin
							$display("FAIL %0t: acknowledge is %b while the line is idle, expected 0",
								$time, tx_ack_i);
							err_cnt++;
						end
						if (line_pending)
							finish_frame();
						else if (pkt_len_i !== exp_pkt_len)
						begin
							$display("FAIL %0t: packet length %0d while idle, expected %0d",
								$time, pkt_len_i, exp_pkt_len);
							err_cnt++;
						end
						idle_run++;
					end
				end
				C_PRE:
				begin
					expect_word("preamble", PREAMBLE, PREAMBLE_K);
					idx++;
					if (idx == PREAMBLE_WORDS)
						cstate = C_SOF;
				end
				C_SOF:
				begin
					expect_word("start of frame", SOF_PRE, SOF_PRE_K);
					idx    = 0;
					cstate = (cur_len == 0) ? C_CRC1 : C_DATA;
				end
				C_DATA:
				begin
					expect_word($sformatf("payload word %0d", idx), cur_words[idx], DATA_FILL_K);
					idx++;
					if (idx == cur_len)
						cstate = C_CRC1;
				end
				C_CRC1:
				begin
					expect_word("first CRC word", exp_crc, DATA_FILL_K);
					cstate = C_CRC2;
				end
				C_CRC2:
				begin
					expect_word("second CRC word", exp_crc, DATA_FILL_K);
					cstate = C_EOP;
				end
				C_EOP:
				begin
					expect_word("end of packet", END_OF_PACKET, END_OF_PACKET_K);
					cstate = C_EXT;
				end
				default:
				begin
					expect_word("carrier extend", CARRIER_EXTEND, CARRIER_EXTEND_K);
					line_pending = 1'b1;
					idle_run     = 0;
					cstate       = C_IDLE;
				end
			endcase
			if (!reset_seen)
			begin
				reset_seen = 1'b1;
				$display("Reset values: %s", (err_cnt == frame_err0) ? "passed" : "wrong");
			end
		end
	end

endmodule

/* tests/tb_daq_frame_tx.sv */
`timescale 1ns/100ps

module tb_daq_frame_tx
	import daq_pkg::*;
();

	localparam int PREAMBLE_WORDS = 2;
	localparam int GAP_WORDS      = 6;
	localparam int N_FRAMES       = 40;
	localparam int MAX_LEN        = 32;
	localparam int MAX_DELAY      = 15;
	// Longest frame plus pipeline and idle slack, for every frame
	localparam int CYCLE_LIMIT =
		N_FRAMES * (MAX_LEN + 2 + 2 + 2 + 4 + MAX_DELAY + GAP_WORDS) + 200;

	logic     usr_clk_wordwise;
	logic     arst;
	word_t    txd;
	logic     txd_vld;
	word_t    tx_data;
	charisk_t tx_charisk;
	logic     tx_ack;
	pkt_len_t pkt_len;
	int       err_cnt;
	int       frames_done;
	int       cycles = 0;

	logic [15:0] lfsr_state = 16'd11162;

	daq_frame_tx #(
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.GAP_WORDS      (GAP_WORDS)
	) u_daq_frame_tx (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd),
		.txd_vld_i        (txd_vld),
		.tx_data_o        (tx_data),
		.tx_charisk_o     (tx_charisk),
		.tx_ack_o         (tx_ack),
		.pkt_len_o        (pkt_len)
	);

	daq_frame_checker #(
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.GAP_WORDS      (GAP_WORDS)
	) u_daq_frame_checker (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.tx_data_i        (tx_data),
		.tx_charisk_i     (tx_charisk),
		.tx_ack_i         (tx_ack),
		.pkt_len_i        (pkt_len),
		.err_cnt_o        (err_cnt),
		.frames_done_o    (frames_done)
	);

	always #20 usr_clk_wordwise = ~usr_clk_wordwise;

	always @(posedge usr_clk_wordwise)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the frames did not all come out", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////
	// Random source
	//////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
	endfunction

	task automatic draw_bits(input int n, output int unsigned val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// Queue one frame for the checker, then hand it over word by word
	task automatic send_frame(input int len, input int delay);
		word_t       payload[$];
		int unsigned r;
		int          idx;
		logic        taken;
		for (int i = 0; i < len; i++)
		begin
			draw_bits(16, r);
			payload.push_back(word_t'(r));
			u_daq_frame_checker.add_word(word_t'(r));
		end
		u_daq_frame_checker.add_frame(len);
		repeat (delay) @(negedge usr_clk_wordwise);
		txd_vld = 1'b1;
		txd     = payload[0];
		idx     = 0;
		while (idx < len)
		begin
			taken = tx_ack;  // Word goes in at the coming rising edge
			@(negedge usr_clk_wordwise);
			if (taken)
			begin
				idx++;
				if (idx < len)
					txd = payload[idx];
			end
		end
		txd_vld = 1'b0;
		draw_bits(16, r);
		txd = word_t'(r);  // Junk that must not reach the line
		@(negedge usr_clk_wordwise);
	endtask

	initial
	begin
		int unsigned len_r;
		int unsigned dly_r;
		int          asrt_fails;
		usr_clk_wordwise = 1'b0;
		arst    = 1'b1;
		txd     = '0;
		txd_vld = 1'b0;
		repeat (10) @(negedge usr_clk_wordwise);
		arst = 1'b0;

		for (int f = 0; f < N_FRAMES; f++)
		begin
			draw_bits(5, len_r);
			draw_bits(4, dly_r);
			send_frame(int'(len_r) + 1, int'(dly_r));
		end
		while (frames_done < N_FRAMES)
			@(negedge usr_clk_wordwise);

		asrt_fails = u_daq_frame_tx.u_daq_frame_asserts.fail_cnt;
		$display("Frames %0d of %0d, check errors %0d, assertion failures %0d",
			frames_done, N_FRAMES, err_cnt, asrt_fails);
		if (err_cnt == 0 && asrt_fails == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
design/daq_pkg.sv
design/frame_fsm.sv
design/word_timer.sv
design/crc16_gen.sv
design/tx_word_pipe.sv
design/pkt_len_counter.sv
design/daq_frame_tx.sv
tests/daq_frame_asserts.sv
tests/daq_frame_checker.sv
tests/tb_daq_frame_tx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_daq_frame_tx -f tb.f -o sim_daq_frame_tx

# Keep going on assertion errors so the testbench can print its verdict
out=$(./obj_dir/sim_daq_frame_tx +verilator+error+limit+1000 || true)
echo "$out"

echo "$out" | grep -qx "TEST RESULT: PASS"
